// File: rtl/mutative_cache_config.svh
`ifndef MUTATIVE_CACHE_CONFIG_SVH
`define MUTATIVE_CACHE_CONFIG_SVH

// cache geometry
`define WAYS            8
`define SETS            16
`define OFFSET_BITS     5
`define SET_BITS        4
`define TAG_BITS        23
`define LINE_BITS       256
`define WAY_IDX_BITS    3

// mode policy
`define SHADOW_ENTRIES  128     // one entry per physical line
`define CONFLICT_LIMIT  4       // conflict misses before the next mode

`endif

// File: rtl/mutative_types.sv
`include "mutative_cache_config.svh"

package mutative_types;

    // one cpu address seen as set-associative fields or as a line number
    typedef union packed {
        struct packed {
            logic [`TAG_BITS-1:0]    tag;
            logic [`SET_BITS-1:0]    set_index;
            logic [`OFFSET_BITS-1:0] offset;
        } sa;
        struct packed {
            logic [`TAG_BITS+`SET_BITS-1:0] line;
            logic [`OFFSET_BITS-1:0]        offset;
        } fa;
    } cache_addr_u;

    // group size is 2**mode
    typedef enum logic [1:0] {
        MODE_DM   = 2'd0,
        MODE_2WAY = 2'd1,
        MODE_4WAY = 2'd2,
        MODE_8WAY = 2'd3
    } assoc_mode_e;

    // The group number is made of the low 3-mode tag bits, with tag[0] as its top bit.
    // A group then covers 2**mode consecutive ways from group*size, and each group of
    // one mode lies inside a group of every higher mode.
    function automatic logic [`WAY_IDX_BITS-1:0] group_base(
        logic [`WAY_IDX_BITS-1:0] tag_low,
        assoc_mode_e              mode
    );
        logic [`WAY_IDX_BITS-1:0] rev;
        rev = {tag_low[0], tag_low[1], tag_low[2]};
        return (rev >> mode) << mode;
    endfunction

endpackage

// File: rtl/mutative_ctrl_if.sv
`timescale 1ns/1ps

interface mutative_ctrl_if;
    logic fill_we;      // refill line into victim way
    logic cpu_we;       // cpu merge into hit way
    logic set_dirty;    // dirty bit stored with the write
    logic wb_en;        // memory port carries victim
    logic miss_done;    // miss classified
    logic ready;        // ufp_resp

    modport fsm (
        output fill_we, cpu_we, set_dirty, wb_en, miss_done, ready
    );

    modport dp (
        input fill_we, cpu_we, set_dirty, wb_en, miss_done, ready
    );
endinterface

// File: rtl/mutative_way_array.sv
`timescale 1ns/1ps
`include "mutative_cache_config.svh"

module mutative_way_array (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [`SET_BITS-1:0]          set_index,
    input  logic [`WAYS-1:0]              we,
    input  logic [`LINE_BITS/8-1:0]       byte_en,
    input  logic [`LINE_BITS-1:0]         wdata,
    input  logic [`TAG_BITS-1:0]          wtag,
    input  logic                          wdirty,
    output logic [`LINE_BITS-1:0]         rdata  [`WAYS],
    output logic [`TAG_BITS-1:0]          rtag   [`WAYS],
    output logic                          rvalid [`WAYS],
    output logic                          rdirty [`WAYS]
);
    logic [`LINE_BITS-1:0] data_mem  [`WAYS][`SETS];
    logic [`TAG_BITS-1:0]  tag_mem   [`WAYS][`SETS];
    logic                  dirty_mem [`WAYS][`SETS];
    logic                  valid_mem [`WAYS][`SETS];

    always_ff @(posedge clk) begin
        for (int w = 0; w < `WAYS; w++) begin
            if (we[w]) begin
                for (int b = 0; b < `LINE_BITS/8; b++) begin
                    if (byte_en[b]) begin
                        data_mem[w][set_index][b*8 +: 8] <= wdata[b*8 +: 8];
                    end
                end
                tag_mem[w][set_index]   <= wtag;
                dirty_mem[w][set_index] <= wdirty;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int w = 0; w < `WAYS; w++) begin
                for (int s = 0; s < `SETS; s++) begin
                    valid_mem[w][s] <= 1'b0;
                end
            end
        end else begin
            for (int w = 0; w < `WAYS; w++) begin
                if (we[w]) begin
                    valid_mem[w][set_index] <= 1'b1;    // any write fills the line
                end
            end
        end
    end

    always_comb begin
        for (int w = 0; w < `WAYS; w++) begin
            rdata[w]  = data_mem[w][set_index];
            rtag[w]   = tag_mem[w][set_index];
            rvalid[w] = valid_mem[w][set_index];
            rdirty[w] = dirty_mem[w][set_index];
        end
    end
endmodule

// File: rtl/mutative_plru.sv
`timescale 1ns/1ps
`include "mutative_cache_config.svh"

module mutative_plru
import mutative_types::*;
(
    input  logic                     clk,
    input  logic                     rst,
    input  logic [`SET_BITS-1:0]     set_index,
    input  logic [`WAY_IDX_BITS-1:0] tag_low,
    input  assoc_mode_e              mode,
    input  logic                     access,
    input  logic [`WAY_IDX_BITS-1:0] hit_way,
    output logic [`WAY_IDX_BITS-1:0] victim_way
);
    // node 0 picks way bit 2, nodes 1-2 bit 1, nodes 3-6 bit 0
    logic [`WAYS-2:0]         tree [`SETS];
    logic [`WAYS-2:0]         node;
    logic [`WAY_IDX_BITS-1:0] base;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < `SETS; s++) begin
                tree[s] <= '0;
            end
        end else if (access) begin
            tree[set_index][0]                <= ~hit_way[2];   // point away from used way
            tree[set_index][1 + hit_way[2]]   <= ~hit_way[1];
            tree[set_index][3 + hit_way[2:1]] <= ~hit_way[0];
        end
    end

    // way bits at or above the mode are fixed by the group
    always_comb begin
        base = group_base(tag_low, mode);
        node = tree[set_index];
        victim_way[2] = (mode <= MODE_4WAY) ? base[2] : node[0];
        victim_way[1] = (mode <= MODE_2WAY) ? base[1] : node[1 + victim_way[2]];
        victim_way[0] = (mode == MODE_DM)   ? base[0] : node[3 + victim_way[2:1]];
    end
endmodule

// File: rtl/mutative_fsm.sv
`timescale 1ns/1ps

module mutative_fsm (
    input  logic          clk,
    input  logic          rst,
    input  logic          cpu_req,
    input  logic          cpu_write,
    input  logic          hit,
    input  logic          victim_dirty,
    input  logic          dfp_resp,
    output logic          dfp_read,
    mutative_ctrl_if.fsm  ctrl
);
    typedef enum logic [2:0] {
        S_IDLE,
        S_COMPARE,
        S_WRITEBACK,
        S_ALLOCATE,
        S_FILL
    } state_e;

    state_e state, state_next;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= S_IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        unique case (state)
            S_IDLE:      if (cpu_req) state_next = S_COMPARE;
            S_COMPARE: begin
                if (!cpu_req || hit) begin
                    state_next = S_IDLE;
                end else begin
                    state_next = victim_dirty ? S_WRITEBACK : S_ALLOCATE;
                end
            end
            S_WRITEBACK: if (dfp_resp) state_next = S_ALLOCATE;
            S_ALLOCATE:  if (dfp_resp) state_next = S_FILL;
            S_FILL:      state_next = S_COMPARE;    // retry lookup, now hits
            default:     state_next = S_IDLE;
        endcase
    end

    assign ctrl.ready     = (state == S_COMPARE) && cpu_req && hit;
    assign ctrl.miss_done = (state == S_COMPARE) && cpu_req && !hit;
    assign ctrl.cpu_we    = ctrl.ready && cpu_write;
    assign ctrl.set_dirty = (state == S_COMPARE);   // refill stores clean
    assign ctrl.wb_en     = (state == S_WRITEBACK);
    assign ctrl.fill_we   = (state == S_FILL);
    assign dfp_read       = (state == S_ALLOCATE);
endmodule

// File: rtl/mutative_mode_select.sv
`timescale 1ns/1ps
`include "mutative_cache_config.svh"

module mutative_mode_select
import mutative_types::*;
(
    input  logic                            clk,
    input  logic                            rst,
    input  logic [`TAG_BITS+`SET_BITS-1:0]  line,
    input  logic                            miss_done,
    input  logic                            fill_we,
    output assoc_mode_e                     mode
);
    localparam int PTR_BITS = $clog2(`SHADOW_ENTRIES);
    localparam int CNT_BITS = $clog2(`CONFLICT_LIMIT + 1);

    logic [`TAG_BITS+`SET_BITS-1:0] shadow_line  [`SHADOW_ENTRIES];
    logic                           shadow_valid [`SHADOW_ENTRIES];
    logic [PTR_BITS-1:0]            wr_ptr;
    logic [CNT_BITS-1:0]            conflict_cnt;
    logic                           shadow_hit;

    // fully associative lookup of the request line
    always_comb begin
        shadow_hit = 1'b0;
        for (int i = 0; i < `SHADOW_ENTRIES; i++) begin
            if (shadow_valid[i] && shadow_line[i] == line) begin
                shadow_hit = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fill_we && !shadow_hit) begin
            shadow_line[wr_ptr] <= line;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `SHADOW_ENTRIES; i++) begin
                shadow_valid[i] <= 1'b0;
            end
            wr_ptr <= '0;
        end else if (fill_we && !shadow_hit) begin
            shadow_valid[wr_ptr] <= 1'b1;
            wr_ptr               <= wr_ptr + 1'b1;  // round robin, oldest goes first
        end
    end

    // a miss on a line filled recently counts as a conflict
    always_ff @(posedge clk) begin
        if (rst) begin
            conflict_cnt <= '0;
            mode         <= MODE_DM;
        end else if (miss_done && shadow_hit) begin
            if (conflict_cnt == CNT_BITS'(`CONFLICT_LIMIT - 1)) begin
                conflict_cnt <= '0;
                if (mode != MODE_8WAY) begin
                    mode <= assoc_mode_e'(mode + 2'd1);    // only ever steps up
                end
            end else begin
                conflict_cnt <= conflict_cnt + 1'b1;
            end
        end
    end
endmodule

// File: rtl/mutative_cache.sv
`timescale 1ns/1ps
`include "mutative_cache_config.svh"

module mutative_cache
import mutative_types::*;
(
    input  logic         clk,
    input  logic         rst,
    input  logic [31:0]  ufp_addr,
    input  logic [3:0]   ufp_rmask,
    input  logic [3:0]   ufp_wmask,
    input  logic [31:0]  ufp_wdata,
    output logic [31:0]  ufp_rdata,
    output logic         ufp_resp,
    output logic [31:0]  dfp_addr,
    output logic         dfp_read,
    output logic         dfp_write,
    input  logic [255:0] dfp_rdata,
    output logic [255:0] dfp_wdata,
    input  logic         dfp_resp,
    output logic [1:0]   assoc_mode
);
    cache_addr_u              addr;
    assoc_mode_e              mode;
    logic                     cpu_req;
    logic                     hit;
    logic [`WAY_IDX_BITS-1:0] hit_way, victim_way, victim_q, grp_base;
    logic [`WAYS-1:0]         in_group, way_we;
    logic [2:0]               word_sel;
    logic [`LINE_BITS/8-1:0]  byte_en;
    logic [`LINE_BITS-1:0]    wdata, fill_line;
    logic [`LINE_BITS-1:0]    rdata  [`WAYS];
    logic [`TAG_BITS-1:0]     rtag   [`WAYS];
    logic                     rvalid [`WAYS];
    logic                     rdirty [`WAYS];

    mutative_ctrl_if ctrl ();

    assign addr     = ufp_addr;
    assign cpu_req  = (|ufp_rmask) || (|ufp_wmask);
    assign word_sel = addr.sa.offset[4:2];
    assign grp_base = group_base(addr.sa.tag[2:0], mode);

    // full tag compare over the valid ways of the current group
    always_comb begin
        hit     = 1'b0;
        hit_way = '0;
        for (int w = 0; w < `WAYS; w++) begin
            in_group[w] = ((`WAY_IDX_BITS'(w) >> mode) == (grp_base >> mode));
            if (in_group[w] && rvalid[w] && rtag[w] == addr.sa.tag) begin
                hit     = 1'b1;
                hit_way = `WAY_IDX_BITS'(w);
            end
        end
    end

    assign ufp_rdata = rdata[hit_way][word_sel*32 +: 32];

    always_ff @(posedge clk) begin
        if (ctrl.miss_done) victim_q <= victim_way;     // held for writeback and fill
        if (dfp_read && dfp_resp) fill_line <= dfp_rdata;
    end

    always_comb begin
        way_we  = '0;
        byte_en = '0;
        wdata   = {(`LINE_BITS/32){ufp_wdata}};
        if (ctrl.fill_we) begin
            way_we[victim_q] = 1'b1;
            byte_en          = '1;
            wdata            = fill_line;
        end else if (ctrl.cpu_we) begin
            way_we[hit_way] = 1'b1;
            byte_en         = (`LINE_BITS/8)'(ufp_wmask) << {word_sel, 2'b00};
        end
    end

    assign dfp_write = ctrl.wb_en;
    assign dfp_wdata = rdata[victim_q];
    assign dfp_addr  = ctrl.wb_en ? {rtag[victim_q], addr.sa.set_index, {`OFFSET_BITS{1'b0}}}
                                  : {addr.fa.line, {`OFFSET_BITS{1'b0}}};
    assign ufp_resp   = ctrl.ready;
    assign assoc_mode = mode;

    mutative_way_array ways (
        .clk(clk), .rst(rst), .set_index(addr.sa.set_index), .we(way_we),
        .byte_en(byte_en), .wdata(wdata), .wtag(addr.sa.tag), .wdirty(ctrl.set_dirty),
        .rdata(rdata), .rtag(rtag), .rvalid(rvalid), .rdirty(rdirty)
    );

    mutative_plru plru (
        .clk(clk), .rst(rst), .set_index(addr.sa.set_index), .tag_low(addr.sa.tag[2:0]),
        .mode(mode), .access(hit), .hit_way(hit_way), .victim_way(victim_way)
    );

    mutative_fsm fsm (
        .clk(clk), .rst(rst), .cpu_req(cpu_req), .cpu_write(|ufp_wmask), .hit(hit),
        .victim_dirty(rvalid[victim_way] && rdirty[victim_way]), .dfp_resp(dfp_resp),
        .dfp_read(dfp_read), .ctrl(ctrl)
    );

    mutative_mode_select mode_sel (
        .clk(clk), .rst(rst), .line(addr.fa.line), .miss_done(ctrl.miss_done),
        .fill_we(ctrl.fill_we), .mode(mode)
    );
endmodule

// File: tb/mutative_cache_assertions.sv
`timescale 1ns/1ps

module mutative_cache_assertions
import mutative_types::*;
(
    input logic        clk,
    input logic        rst,
    input logic [3:0]  ufp_rmask,
    input logic [3:0]  ufp_wmask,
    input logic        ufp_resp,
    input logic [31:0] dfp_addr,
    input logic        dfp_read,
    input logic        dfp_write,
    input logic        dfp_resp,
    input logic [1:0]  assoc_mode
);
    int error_count = 0;    // polled by the testbench

    quiet_after_reset: assert property (@(posedge clk)
        rst |=> !ufp_resp && !dfp_read && !dfp_write && assoc_mode == MODE_DM)
    else begin
        $error("Error %0t: port active or mode not DM after reset", $time);
        error_count++;
    end

    read_write_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(dfp_read && dfp_write))
    else begin
        $error("Error %0t: dfp_read and dfp_write high together", $time);
        error_count++;
    end

    read_held: assert property (@(posedge clk) disable iff (rst)
        dfp_read && !dfp_resp |=> dfp_read && $stable(dfp_addr))
    else begin
        $error("Error %0t: dfp_read dropped or dfp_addr moved before dfp_resp", $time);
        error_count++;
    end

    write_held: assert property (@(posedge clk) disable iff (rst)
        dfp_write && !dfp_resp |=> dfp_write && $stable(dfp_addr))
    else begin
        $error("Error %0t: dfp_write dropped or dfp_addr moved before dfp_resp", $time);
        error_count++;
    end

    resp_needs_request: assert property (@(posedge clk) disable iff (rst)
        ufp_resp |-> (ufp_rmask != 4'h0 || ufp_wmask != 4'h0))
    else begin
        $error("Error %0t: ufp_resp without a request", $time);
        error_count++;
    end

    mode_monotonic: assert property (@(posedge clk) disable iff (rst)
        assoc_mode >= $past(assoc_mode))
    else begin
        $error("Error %0t: assoc_mode stepped down", $time);
        error_count++;
    end
endmodule

// File: tb/tb_mutative_cache.sv
`timescale 1ns/1ps
`include "mutative_cache_config.svh"

module tb_mutative_cache
import mutative_types::*;
();
    localparam int MAX_CYCLES = 20000;          // ~40 accesses, each far below 100 cycles
    localparam logic [31:0] LINE_A = 32'h0000_0040;
    localparam logic [31:0] LINE_B = 32'h0000_1040;     // same set and DM way as LINE_A

    logic         clk, rst;
    logic [31:0]  ufp_addr, ufp_wdata, ufp_rdata, dfp_addr;
    logic [3:0]   ufp_rmask, ufp_wmask;
    logic         ufp_resp, dfp_read, dfp_write, dfp_resp;
    logic [255:0] dfp_rdata, dfp_wdata;
    logic [1:0]   assoc_mode;
    logic [255:0] mem     [256];    // memory lines, addr[12:5]
    logic [255:0] ref_mem [256];    // what the cpu should see
    int           seed = 5;
    int           mem_delay;
    int           wb_count;
    int           cycles = 0;

    mutative_cache uut (
        .clk(clk), .rst(rst), .ufp_addr(ufp_addr), .ufp_rmask(ufp_rmask),
        .ufp_wmask(ufp_wmask), .ufp_wdata(ufp_wdata), .ufp_rdata(ufp_rdata),
        .ufp_resp(ufp_resp), .dfp_addr(dfp_addr), .dfp_read(dfp_read),
        .dfp_write(dfp_write), .dfp_rdata(dfp_rdata), .dfp_wdata(dfp_wdata),
        .dfp_resp(dfp_resp), .assoc_mode(assoc_mode)
    );

    bind mutative_cache mutative_cache_assertions chk (
        .clk(clk), .rst(rst), .ufp_rmask(ufp_rmask), .ufp_wmask(ufp_wmask),
        .ufp_resp(ufp_resp), .dfp_addr(dfp_addr), .dfp_read(dfp_read),
        .dfp_write(dfp_write), .dfp_resp(dfp_resp), .assoc_mode(assoc_mode)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic fail_run();
        $display("Test FAILED");
        $fatal(1);
    endtask

    always @(negedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            fail_run();
        end else if (uut.chk.error_count != 0) begin
            fail_run();
        end
    end

    // memory model, answers after 2 to 5 cycles
    initial begin
        for (int i = 0; i < 256; i++) begin
            for (int w = 0; w < 8; w++) begin
                mem[i][w*32 +: 32] = $random(seed);
            end
            ref_mem[i] = mem[i];
        end
        mem_delay = 0;
        wb_count  = 0;
        dfp_resp  = 1'b0;
        dfp_rdata = '0;
        forever begin
            @(negedge clk);
            dfp_resp = 1'b0;
            if (!rst && (dfp_read || dfp_write)) begin
                if (mem_delay == 0) begin
                    mem_delay = 2 + ($unsigned($random(seed)) % 4);
                end else begin
                    mem_delay = mem_delay - 1;
                    if (mem_delay == 0) begin
                        if (dfp_write) begin
                            assert (dfp_addr[31:13] == '0 &&
                                    dfp_wdata == ref_mem[dfp_addr[12:5]]) else begin
                                $display("Error %0t: writeback of %h carries wrong data",
                                         $time, dfp_addr);
                                fail_run();
                            end
                            mem[dfp_addr[12:5]] = dfp_wdata;
                            wb_count++;
                        end else begin
                            dfp_rdata = mem[dfp_addr[12:5]];
                        end
                        dfp_resp = 1'b1;
                    end
                end
            end
        end
    end

    // one cpu request, held until ufp_resp and through the edge that takes it
    task automatic cpu_access(input logic [31:0] addr, input logic [3:0] wmask,
                              input logic [31:0] wdata, input bit expect_hit);
        int          waited;
        bit          saw_read;
        logic [7:0]  line;
        logic [2:0]  word;
        logic [31:0] expected;
        line      = addr[12:5];
        word      = addr[4:2];
        waited    = 0;
        saw_read  = 1'b0;
        ufp_addr  = addr;
        ufp_rmask = (wmask == 4'h0) ? 4'hf : 4'h0;
        ufp_wmask = wmask;
        ufp_wdata = wdata;
        do begin
            @(negedge clk);
            waited++;
            if (dfp_read) saw_read = 1'b1;
        end while (!ufp_resp);
        expected = ref_mem[line][word*32 +: 32];
        if (wmask == 4'h0) begin
            assert (ufp_rdata == expected) else begin
                $display("Error %0t: read of %h returned %h, expected %h",
                         $time, addr, ufp_rdata, expected);
                fail_run();
            end
        end
        for (int b = 0; b < 4; b++) begin
            if (wmask[b]) ref_mem[line][word*32 + b*8 +: 8] = wdata[b*8 +: 8];
        end
        if (expect_hit) begin
            assert (waited == 1 && !saw_read) else begin
                $display("Error %0t: access to %h took %0d cycles, not a hit",
                         $time, addr, waited);
                fail_run();
            end
        end
        @(negedge clk);
        ufp_rmask = 4'h0;
        ufp_wmask = 4'h0;
    endtask

    task automatic check_mode(input assoc_mode_e expected);
        assert (assoc_mode == expected) else begin
            $display("Error %0t: assoc_mode is %0d, expected %0d", $time, assoc_mode, expected);
            fail_run();
        end
    endtask

    initial begin
        rst       = 1'b1;
        ufp_addr  = '0;
        ufp_rmask = 4'h0;
        ufp_wmask = 4'h0;
        ufp_wdata = '0;
        repeat (8) @(negedge clk);
        rst = 1'b0;
        check_mode(MODE_DM);

        cpu_access(32'h0000_010c, 4'h0, '0, 1'b0);  // read miss
        cpu_access(32'h0000_010c, 4'h0, '0, 1'b1);

        // byte merges into the resident line
        cpu_access(32'h0000_0104, 4'b0011, 32'hdead_beef, 1'b1);
        cpu_access(32'h0000_0104, 4'b1000, 32'h5a00_0000, 1'b1);
        cpu_access(32'h0000_011c, 4'b0101, 32'h1234_5678, 1'b1);
        cpu_access(32'h0000_0104, 4'h0, '0, 1'b1);
        cpu_access(32'h0000_011c, 4'h0, '0, 1'b1);
        cpu_access(32'h0000_0100, 4'h0, '0, 1'b1);

        // ping-pong on one DM way until the mode steps up
        for (int i = 0; i < `CONFLICT_LIMIT + 2; i++) begin
            if (i == `CONFLICT_LIMIT + 1) check_mode(MODE_DM);
            cpu_access(i[0] ? LINE_B : LINE_A, 4'h0, '0, 1'b0);
        end
        check_mode(MODE_2WAY);
        cpu_access(LINE_A, 4'h0, '0, 1'b0);     // victim was picked under DM
        cpu_access(LINE_B, 4'h0, '0, 1'b1);
        cpu_access(LINE_A, 4'h0, '0, 1'b1);

        // nine dirty lines in set 5 overflow any group
        for (int t = 0; t < 9; t++) begin
            cpu_access((t << 9) | 32'h0a0 | ((t % 8) << 2), 4'hf, 32'h0bad_0000 + t, 1'b0);
        end
        for (int t = 0; t < 9; t++) begin
            cpu_access((t << 9) | 32'h0a0 | ((t % 8) << 2), 4'h0, '0, 1'b0);
        end
        assert (wb_count > 0) else begin
            $display("Error %0t: no writeback happened while evicting dirty lines", $time);
            fail_run();
        end

        if (uut.chk.error_count == 0) begin
            $display("Test OK");
            $finish;
        end else begin
            fail_run();
        end
    end
endmodule

// File: files.f
+incdir+rtl
rtl/mutative_types.sv
rtl/mutative_ctrl_if.sv
rtl/mutative_way_array.sv
rtl/mutative_plru.sv
rtl/mutative_fsm.sv
rtl/mutative_mode_select.sv
rtl/mutative_cache.sv
tb/mutative_cache_assertions.sv
tb/tb_mutative_cache.sv

// File: Bender.yml
package:
  name: mutative_cache

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/mutative_types.sv
      - rtl/mutative_ctrl_if.sv
      - rtl/mutative_way_array.sv
      - rtl/mutative_plru.sv
      - rtl/mutative_fsm.sv
      - rtl/mutative_mode_select.sv
      - rtl/mutative_cache.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - tb/mutative_cache_assertions.sv
      - tb/tb_mutative_cache.sv
